/* build.f */
+incdir+common
common/mips_isa_pkg.sv
common/mips_pipe_pkg.sv
hw/fetch/pc_unit.sv
hw/decode/regfile.sv
hw/decode/decode.sv
hw/alu_ex.sv
hw/mips_core_top.sv
tb/core_properties.sv
tb/tb_core.sv

/* common/mips_defines.svh */
// Core-wide widths, register count and reset vector.
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Data and address width.
`define MIPS_XLEN 32

// Register address width.
`define MIPS_REG_AW 5

// Number of general purpose registers.
`define MIPS_NREGS 32

// First fetch address after reset.
`define MIPS_RESET_PC 32'h0000_0000

`endif

/* common/mips_isa_pkg.sv */
// MIPS32 encodings for the integer subset.
// Major opcodes, R-type function codes and the two views of an instruction word.
`default_nettype none

`include "mips_defines.svh"

package mips_isa_pkg;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } funct_e;

    typedef struct packed {
        opcode_e                 op;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [`MIPS_REG_AW-1:0] rd;
        logic [4:0]              shamt;
        funct_e                  funct;
    } inst_r_t;

    typedef struct packed {
        opcode_e                 op;
        logic [`MIPS_REG_AW-1:0] rs;
        logic [`MIPS_REG_AW-1:0] rt;
        logic [15:0]             imm16;
    } inst_i_t;

    // Same 32-bit word, read as register or immediate format.
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
    } inst_u;

endpackage

`default_nettype wire

/* common/mips_pipe_pkg.sv */
// Pipeline types: ALU operation code, stage records and forwarding source.
`default_nettype none

`include "mips_defines.svh"

package mips_pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_LUI  = 4'd7
    } alu_op_e;

    // Decode to execute.
    typedef struct packed {
        logic [`MIPS_XLEN-1:0]   pc;
        alu_op_e                 alu_op;
        logic [`MIPS_XLEN-1:0]   opr1;
        logic [`MIPS_XLEN-1:0]   opr2;
        logic [`MIPS_XLEN-1:0]   st_data;
        logic                    mem_rd;
        logic                    mem_wr;
        logic                    wreg;
        logic [`MIPS_REG_AW-1:0] wraddr;
    } id_ex_t;

    // Execute to memory. Result doubles as the data address.
    typedef struct packed {
        logic [`MIPS_XLEN-1:0]   pc;
        logic [`MIPS_XLEN-1:0]   result;
        logic [`MIPS_XLEN-1:0]   st_data;
        logic                    mem_rd;
        logic                    mem_wr;
        logic                    wreg;
        logic [`MIPS_REG_AW-1:0] wraddr;
    } ex_mem_t;

    // Memory to writeback.
    typedef struct packed {
        logic [`MIPS_XLEN-1:0]   pc;
        logic [`MIPS_XLEN-1:0]   wrdata;
        logic                    wreg;
        logic [`MIPS_REG_AW-1:0] wraddr;
    } mem_wb_t;

    typedef struct packed {
        logic                    valid;
        logic [`MIPS_REG_AW-1:0] wraddr;
        logic [`MIPS_XLEN-1:0]   data;
    } fwd_t;

endpackage

`default_nettype wire

/* hw/alu_ex.sv */
// Execute stage: integer ALU and data address generation.
`default_nettype none

`include "mips_defines.svh"

module alu_ex (
    input  wire  mips_pipe_pkg::id_ex_t id_ex_i,
    output mips_pipe_pkg::ex_mem_t      ex_mem_o,
    output mips_pipe_pkg::fwd_t         fwd_ex_o
);

    logic [`MIPS_XLEN-1:0] a;
    logic [`MIPS_XLEN-1:0] b;
    logic [`MIPS_XLEN-1:0] result;

    assign a = id_ex_i.opr1;
    assign b = id_ex_i.opr2;

    // Loads and stores use ADD, so the result is the address.
    always_comb begin
        case (id_ex_i.alu_op)
            mips_pipe_pkg::ALU_SUB:  result = a - b;
            mips_pipe_pkg::ALU_AND:  result = a & b;
            mips_pipe_pkg::ALU_OR:   result = a | b;
            mips_pipe_pkg::ALU_XOR:  result = a ^ b;
            mips_pipe_pkg::ALU_SLT:  result = {{(`MIPS_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            mips_pipe_pkg::ALU_SLTU: result = {{(`MIPS_XLEN-1){1'b0}}, a < b};
            mips_pipe_pkg::ALU_LUI:  result = {b[15:0], {(`MIPS_XLEN-16){1'b0}}};
            default:                 result = a + b;
        endcase
    end

    always_comb begin
        ex_mem_o.pc      = id_ex_i.pc;
        ex_mem_o.result  = result;
        ex_mem_o.st_data = id_ex_i.st_data;
        ex_mem_o.mem_rd  = id_ex_i.mem_rd;
        ex_mem_o.mem_wr  = id_ex_i.mem_wr;
        ex_mem_o.wreg    = id_ex_i.wreg;
        ex_mem_o.wraddr  = id_ex_i.wraddr;
    end

    // Load data is not available yet.
    assign fwd_ex_o.valid  = id_ex_i.wreg && !id_ex_i.mem_rd;
    assign fwd_ex_o.wraddr = id_ex_i.wraddr;
    assign fwd_ex_o.data   = result;

endmodule

`default_nettype wire

/* hw/decode/decode.sv */
// Decode stage: operand selection, branch resolution and load-use detection.
// Emits a bubble record while holding.
`default_nettype none

`include "mips_defines.svh"

module decode (
    input  wire  [`MIPS_XLEN-1:0]   id_pc_i,
    input  wire  [`MIPS_XLEN-1:0]   id_inst_i,
    input  wire  [`MIPS_XLEN-1:0]   rs_data_i,
    input  wire  [`MIPS_XLEN-1:0]   rt_data_i,
    input  wire                     ex_is_load_i,
    input  wire  [`MIPS_REG_AW-1:0] ex_wraddr_i,
    output logic [`MIPS_REG_AW-1:0] rs_addr_o,
    output logic [`MIPS_REG_AW-1:0] rt_addr_o,
    output logic                    br_taken_o,
    output logic [`MIPS_XLEN-1:0]   br_target_o,
    output logic                    hold_o,
    output mips_pipe_pkg::id_ex_t   id_ex_o
);

    mips_isa_pkg::inst_u   inst;
    mips_pipe_pkg::id_ex_t rec;
    logic                  rs_used;
    logic                  rt_used;
    logic                  is_branch;
    logic                  operands_eq;
    logic [`MIPS_XLEN-1:0] imm_sext;
    logic [`MIPS_XLEN-1:0] imm_zext;

    assign inst      = id_inst_i;
    assign rs_addr_o = inst.i.rs;
    assign rt_addr_o = inst.i.rt;
    assign imm_sext  = {{(`MIPS_XLEN-16){inst.i.imm16[15]}}, inst.i.imm16};
    assign imm_zext  = {{(`MIPS_XLEN-16){1'b0}}, inst.i.imm16};

    always_comb begin
        rec         = '0;
        rec.pc      = id_pc_i;
        rec.alu_op  = mips_pipe_pkg::ALU_ADD;
        rec.opr1    = rs_data_i;
        rec.opr2    = imm_sext;
        rec.st_data = rt_data_i;
        rs_used     = 1'b0;
        rt_used     = 1'b0;
        is_branch   = 1'b0;
        case (inst.r.op)
            mips_isa_pkg::OP_SPECIAL: begin
                rec.opr2   = rt_data_i;
                rec.wreg   = 1'b1;
                rec.wraddr = inst.r.rd;
                rs_used    = 1'b1;
                rt_used    = 1'b1;
                case (inst.r.funct)
                    mips_isa_pkg::F_ADDU: rec.alu_op = mips_pipe_pkg::ALU_ADD;
                    mips_isa_pkg::F_SUBU: rec.alu_op = mips_pipe_pkg::ALU_SUB;
                    mips_isa_pkg::F_AND:  rec.alu_op = mips_pipe_pkg::ALU_AND;
                    mips_isa_pkg::F_OR:   rec.alu_op = mips_pipe_pkg::ALU_OR;
                    mips_isa_pkg::F_XOR:  rec.alu_op = mips_pipe_pkg::ALU_XOR;
                    mips_isa_pkg::F_SLT:  rec.alu_op = mips_pipe_pkg::ALU_SLT;
                    mips_isa_pkg::F_SLTU: rec.alu_op = mips_pipe_pkg::ALU_SLTU;
                    default: begin
                        rec.wreg = 1'b0;
                        rs_used  = 1'b0;
                        rt_used  = 1'b0;
                    end
                endcase
            end
            mips_isa_pkg::OP_ADDIU: begin
                rec.wreg   = 1'b1;
                rec.wraddr = inst.i.rt;
                rs_used    = 1'b1;
            end
            mips_isa_pkg::OP_ORI: begin
                rec.alu_op = mips_pipe_pkg::ALU_OR;
                rec.opr2   = imm_zext;
                rec.wreg   = 1'b1;
                rec.wraddr = inst.i.rt;
                rs_used    = 1'b1;
            end
            mips_isa_pkg::OP_LUI: begin
                rec.alu_op = mips_pipe_pkg::ALU_LUI;
                rec.opr2   = imm_zext;
                rec.wreg   = 1'b1;
                rec.wraddr = inst.i.rt;
            end
            mips_isa_pkg::OP_LW: begin
                rec.mem_rd = 1'b1;
                rec.wreg   = 1'b1;
                rec.wraddr = inst.i.rt;
                rs_used    = 1'b1;
            end
            mips_isa_pkg::OP_SW: begin
                rec.mem_wr = 1'b1;
                rs_used    = 1'b1;
                rt_used    = 1'b1;
            end
            mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE: begin
                is_branch = 1'b1;
                rs_used   = 1'b1;
                rt_used   = 1'b1;
            end
            default: ;
        endcase
        // Writes to $0 are dropped here so nothing downstream sees them.
        if (rec.wraddr == '0) begin
            rec.wreg = 1'b0;
        end
    end

    // A load result is not ready until the load leaves execute.
    assign hold_o = ex_is_load_i && (ex_wraddr_i != '0) &&
                    ((rs_used && (inst.i.rs == ex_wraddr_i)) ||
                     (rt_used && (inst.i.rt == ex_wraddr_i)));

    assign operands_eq = (rs_data_i == rt_data_i);

    // BEQ takes on equal operands, BNE on unequal ones.
    assign br_taken_o  = is_branch && !hold_o &&
                         ((inst.i.op == mips_isa_pkg::OP_BEQ) == operands_eq);
    assign br_target_o = id_pc_i + `MIPS_XLEN'(4) + {imm_sext[`MIPS_XLEN-3:0], 2'b00};

    assign id_ex_o = hold_o ? '0 : rec;

endmodule

`default_nettype wire

/* hw/decode/regfile.sv */
// General purpose register file with bypass from execute, memory and writeback.
`default_nettype none

`include "mips_defines.svh"

module regfile (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire  [`MIPS_REG_AW-1:0] rs_addr_i,
    input  wire  [`MIPS_REG_AW-1:0] rt_addr_i,
    input  wire                     we_i,
    input  wire  [`MIPS_REG_AW-1:0] waddr_i,
    input  wire  [`MIPS_XLEN-1:0]   wdata_i,
    input  wire  mips_pipe_pkg::fwd_t fwd_ex_i,
    input  wire  mips_pipe_pkg::fwd_t fwd_mem_i,
    output logic [`MIPS_XLEN-1:0]   rs_data_o,
    output logic [`MIPS_XLEN-1:0]   rt_data_o
);

    logic [`MIPS_XLEN-1:0] regs_q [`MIPS_NREGS];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    // Youngest producer wins.
    function automatic logic [`MIPS_XLEN-1:0] read_port(
        input logic [`MIPS_REG_AW-1:0] addr
    );
        logic [`MIPS_XLEN-1:0] data;
        if (addr == '0) begin
            data = '0;
        end else if (fwd_ex_i.valid && (fwd_ex_i.wraddr == addr)) begin
            data = fwd_ex_i.data;
        end else if (fwd_mem_i.valid && (fwd_mem_i.wraddr == addr)) begin
            data = fwd_mem_i.data;
        end else if (we_i && (waddr_i == addr)) begin
            data = wdata_i;
        end else begin
            data = regs_q[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs_data_o = read_port(rs_addr_i);
        rt_data_o = read_port(rt_addr_i);
    end

endmodule

`default_nettype wire

/* hw/fetch/pc_unit.sv */
// Fetch stage: program counter, branch redirect and the IF/ID register.
`default_nettype none

`include "mips_defines.svh"

module pc_unit (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire                     hold_i,
    input  wire                     br_taken_i,
    input  wire  [`MIPS_XLEN-1:0]   br_target_i,
    input  wire  [`MIPS_XLEN-1:0]   ibus_rdata_i,
    output logic [`MIPS_XLEN-1:0]   ibus_addr_o,
    output logic                    ibus_en_o,
    output logic [`MIPS_XLEN-1:0]   id_pc_o,
    output logic [`MIPS_XLEN-1:0]   id_inst_o
);

    logic [`MIPS_XLEN-1:0] pc_q;
    logic [`MIPS_XLEN-1:0] pc_next;

    // The branch sits in decode while its delay slot is fetched here.
    always_comb begin
        if (hold_i) begin
            pc_next = pc_q;
        end else if (br_taken_i) begin
            pc_next = br_target_i;
        end else begin
            pc_next = pc_q + `MIPS_XLEN'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= `MIPS_RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // IF/ID. An all-zero word decodes as a no-op.
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_pc_o   <= '0;
            id_inst_o <= '0;
        end else if (!hold_i) begin
            id_pc_o   <= pc_q;
            id_inst_o <= ibus_rdata_i;
        end
    end

    assign ibus_addr_o = pc_q;
    assign ibus_en_o   = 1'b1;

endmodule

`default_nettype wire

/* hw/mips_core_top.sv */
// Five-stage MIPS32 integer core.
// Holds ID/EX, EX/MEM and MEM/WB, drives the data bus and the debug ports.
`default_nettype none

`include "mips_defines.svh"

module mips_core_top (
    input  wire                     clk,
    input  wire                     rst_n_i,

    output logic                    ibus_en_o,
    output logic [`MIPS_XLEN-1:0]   ibus_addr_o,
    input  wire  [`MIPS_XLEN-1:0]   ibus_rdata_i,

    output logic                    dbus_en_o,
    output logic [`MIPS_XLEN-1:0]   dbus_addr_o,
    input  wire  [`MIPS_XLEN-1:0]   dbus_rdata_i,
    output logic [3:0]              dbus_wen_o,
    output logic [`MIPS_XLEN-1:0]   dbus_wdata_o,

    output logic [`MIPS_XLEN-1:0]   debug_wb_pc_o,
    output logic [3:0]              debug_wb_wreg_o,
    output logic [`MIPS_REG_AW-1:0] debug_wb_wraddr_o,
    output logic [`MIPS_XLEN-1:0]   debug_wb_wrdata_o
);

    logic [`MIPS_XLEN-1:0]   id_pc;
    logic [`MIPS_XLEN-1:0]   id_inst;
    logic [`MIPS_REG_AW-1:0] rs_addr;
    logic [`MIPS_REG_AW-1:0] rt_addr;
    logic [`MIPS_XLEN-1:0]   rs_data;
    logic [`MIPS_XLEN-1:0]   rt_data;
    logic                    br_taken;
    logic [`MIPS_XLEN-1:0]   br_target;
    logic                    hold;

    mips_pipe_pkg::id_ex_t   id_ex_d;
    mips_pipe_pkg::id_ex_t   id_ex_q;
    mips_pipe_pkg::ex_mem_t  ex_mem_d;
    mips_pipe_pkg::ex_mem_t  ex_mem_q;
    mips_pipe_pkg::mem_wb_t  mem_wb_d;
    mips_pipe_pkg::mem_wb_t  mem_wb_q;
    mips_pipe_pkg::fwd_t     fwd_ex;
    mips_pipe_pkg::fwd_t     fwd_mem;

    pc_unit u_pc_unit (
        .clk          (clk          ),
        .rst_n_i      (rst_n_i      ),
        .hold_i       (hold         ),
        .br_taken_i   (br_taken     ),
        .br_target_i  (br_target    ),
        .ibus_rdata_i (ibus_rdata_i ),
        .ibus_addr_o  (ibus_addr_o  ),
        .ibus_en_o    (ibus_en_o    ),
        .id_pc_o      (id_pc        ),
        .id_inst_o    (id_inst      )
    );

    decode u_decode (
        .id_pc_i      (id_pc          ),
        .id_inst_i    (id_inst        ),
        .rs_data_i    (rs_data        ),
        .rt_data_i    (rt_data        ),
        .ex_is_load_i (id_ex_q.mem_rd ),
        .ex_wraddr_i  (id_ex_q.wraddr ),
        .rs_addr_o    (rs_addr        ),
        .rt_addr_o    (rt_addr        ),
        .br_taken_o   (br_taken       ),
        .br_target_o  (br_target      ),
        .hold_o       (hold           ),
        .id_ex_o      (id_ex_d        )
    );

    regfile u_regfile (
        .clk          (clk             ),
        .rst_n_i      (rst_n_i         ),
        .rs_addr_i    (rs_addr         ),
        .rt_addr_i    (rt_addr         ),
        .we_i         (mem_wb_q.wreg   ),
        .waddr_i      (mem_wb_q.wraddr ),
        .wdata_i      (mem_wb_q.wrdata ),
        .fwd_ex_i     (fwd_ex          ),
        .fwd_mem_i    (fwd_mem         ),
        .rs_data_o    (rs_data         ),
        .rt_data_o    (rt_data         )
    );

    alu_ex u_alu_ex (
        .id_ex_i      (id_ex_q  ),
        .ex_mem_o     (ex_mem_d ),
        .fwd_ex_o     (fwd_ex   )
    );

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_ex_q  <= '0;
            ex_mem_q <= '0;
            mem_wb_q <= '0;
        end else begin
            id_ex_q  <= id_ex_d;
            ex_mem_q <= ex_mem_d;
            mem_wb_q <= mem_wb_d;
        end
    end

    // Memory stage. Read data arrives in the same cycle as the address.
    always_comb begin
        mem_wb_d.pc     = ex_mem_q.pc;
        mem_wb_d.wrdata = ex_mem_q.mem_rd ? dbus_rdata_i : ex_mem_q.result;
        mem_wb_d.wreg   = ex_mem_q.wreg;
        mem_wb_d.wraddr = ex_mem_q.wraddr;
    end

    assign fwd_mem.valid  = ex_mem_q.wreg;
    assign fwd_mem.wraddr = ex_mem_q.wraddr;
    assign fwd_mem.data   = mem_wb_d.wrdata;

    assign dbus_en_o    = ex_mem_q.mem_rd | ex_mem_q.mem_wr;
    assign dbus_wen_o   = {4{ex_mem_q.mem_wr}};
    assign dbus_addr_o  = ex_mem_q.result;
    assign dbus_wdata_o = ex_mem_q.st_data;

    assign debug_wb_pc_o     = mem_wb_q.pc;
    assign debug_wb_wreg_o   = {4{mem_wb_q.wreg}};
    assign debug_wb_wraddr_o = mem_wb_q.wraddr;
    assign debug_wb_wrdata_o = mem_wb_q.wrdata;

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the core testbench with Verilator and runs it.
# The verdict comes from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_core -Mdir obj_dir -f build.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_core > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation finished without failure"
exit 0

/* tb/core_properties.sv */
// Concurrent assertions on the bus strobes, fetch alignment and debug writeback.
`default_nettype none

`include "mips_defines.svh"

module core_properties (
    input wire                   clk,
    input wire                   rst_n_i,
    input wire                   ibus_en_i,
    input wire [`MIPS_XLEN-1:0]  ibus_addr_i,
    input wire                   dbus_en_i,
    input wire [3:0]             dbus_wen_i,
    input wire [3:0]             debug_wb_wreg_i
);

    // Byte enables only accompany an active data access.
    wen_needs_en: assert property (@(posedge clk) disable iff (!rst_n_i)
        (dbus_wen_i != 4'h0) |-> dbus_en_i)
        else $error("data bus write enable raised without data bus enable");

    wreg_all_or_none: assert property (@(posedge clk) disable iff (!rst_n_i)
        (debug_wb_wreg_i == 4'h0) || (debug_wb_wreg_i == 4'hf))
        else $error("debug writeback enable is neither all ones nor zero");

    fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n_i)
        ibus_addr_i[1:0] == 2'b00)
        else $error("instruction fetch address is not word aligned");

    fetch_enabled: assert property (@(posedge clk) disable iff (!rst_n_i)
        ibus_en_i)
        else $error("instruction bus enable dropped out of reset");

endmodule

`default_nettype wire

/* tb/tb_core.sv */
// Testbench for the five-stage core.
// Random program generator, instruction and data memories, ISA reference model and checks.
`default_nettype none

`include "mips_defines.svh"

module tb_core;

    localparam int          PROG_LEN       = 200;
    localparam logic [31:0] END_PC         = 32'(PROG_LEN * 4);
    localparam int          TIMEOUT_CYCLES = 2000;

    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    typedef struct packed {
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [31:0] val;
    } wb_rec_t;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } st_rec_t;

    logic                    clk;
    logic                    rst_n_i;
    logic                    ibus_en;
    logic [`MIPS_XLEN-1:0]   ibus_addr;
    logic [`MIPS_XLEN-1:0]   ibus_rdata;
    logic                    dbus_en;
    logic [`MIPS_XLEN-1:0]   dbus_addr;
    logic [`MIPS_XLEN-1:0]   dbus_rdata;
    logic [3:0]              dbus_wen;
    logic [`MIPS_XLEN-1:0]   dbus_wdata;
    logic [`MIPS_XLEN-1:0]   wb_pc;
    logic [3:0]              wb_wreg;
    logic [`MIPS_REG_AW-1:0] wb_wraddr;
    logic [`MIPS_XLEN-1:0]   wb_wrdata;

    logic [31:0] imem [256];
    logic [31:0] dmem [64];

    wb_rec_t exp_wb [$];
    st_rec_t exp_st [$];
    wb_rec_t got_wb;
    wb_rec_t want_wb;
    st_rec_t got_st;
    st_rec_t want_st;

    mips_core_top DUT (
        .clk               (clk        ),
        .rst_n_i           (rst_n_i    ),
        .ibus_en_o         (ibus_en    ),
        .ibus_addr_o       (ibus_addr  ),
        .ibus_rdata_i      (ibus_rdata ),
        .dbus_en_o         (dbus_en    ),
        .dbus_addr_o       (dbus_addr  ),
        .dbus_rdata_i      (dbus_rdata ),
        .dbus_wen_o        (dbus_wen   ),
        .dbus_wdata_o      (dbus_wdata ),
        .debug_wb_pc_o     (wb_pc      ),
        .debug_wb_wreg_o   (wb_wreg    ),
        .debug_wb_wraddr_o (wb_wraddr  ),
        .debug_wb_wrdata_o (wb_wrdata  )
    );

    bind mips_core_top core_properties u_core_properties (
        .clk             (clk             ),
        .rst_n_i         (rst_n_i         ),
        .ibus_en_i       (ibus_en_o       ),
        .ibus_addr_i     (ibus_addr_o     ),
        .dbus_en_i       (dbus_en_o       ),
        .dbus_wen_i      (dbus_wen_o      ),
        .debug_wb_wreg_i (debug_wb_wreg_o )
    );

    always #20 clk = ~clk;

    // Both memories answer in the same cycle.
    assign ibus_rdata = imem[ibus_addr[9:2]];
    assign dbus_rdata = dmem[dbus_addr[7:2]];

    always @(posedge clk) begin
        if (dbus_en && (dbus_wen == 4'hf)) begin
            dmem[dbus_addr[7:2]] <= dbus_wdata;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [5:0] funct_code(input int unsigned k);
        logic [5:0] f;
        case (k)
            0:       f = 6'h21;
            1:       f = 6'h23;
            2:       f = 6'h24;
            3:       f = 6'h25;
            4:       f = 6'h26;
            5:       f = 6'h2a;
            default: f = 6'h2b;
        endcase
        return f;
    endfunction

    // Small register pool so that neighbours often depend on each other.
    function automatic logic [31:0] random_inst(input int idx, input bit no_branch);
        int unsigned kind;
        int          off;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [15:0] woff;
        logic [31:0] word;
        kind = no_branch ? $urandom_range(11, 0) : $urandom_range(13, 0);
        rs   = 5'($urandom_range(7, 0));
        rt   = 5'($urandom_range(7, 0));
        rd   = 5'($urandom_range(7, 0));
        imm  = 16'($urandom());
        woff = 16'($urandom_range(63, 0) * 4);
        off  = int'($urandom_range(7, 1));
        if (idx + 1 + off > PROG_LEN) begin
            off = PROG_LEN - idx - 1;
        end
        if (kind < 7) begin
            word = {6'h00, rs, rt, rd, 5'd0, funct_code(kind)};
        end else begin
            case (kind)
                7:       word = {OP_ADDIU, rs, rt, imm};
                8:       word = {OP_ORI, rs, rt, imm};
                9:       word = {OP_LUI, 5'd0, rt, imm};
                10:      word = {OP_LW, 5'd0, rt, woff};
                11:      word = {OP_SW, 5'd0, rt, woff};
                12:      word = {OP_BEQ, rs, rt, 16'(off)};
                default: word = {OP_BNE, rs, rt, 16'(off)};
            endcase
        end
        return word;
    endfunction

    // Architectural model with one delay slot per branch.
    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] mem [64];
        logic [31:0] pc;
        logic [31:0] npc;
        logic [31:0] nnpc;
        logic [31:0] inst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] res;
        logic [31:0] addr;
        logic [4:0]  rd;
        wb_rec_t     wb;
        st_rec_t     st;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < 64; i++) begin
            mem[i] = dmem[i];
        end
        pc    = `MIPS_RESET_PC;
        npc   = pc + 32'd4;
        steps = 0;
        while ((pc != END_PC) && (steps < 4 * PROG_LEN)) begin
            inst = imem[pc[9:2]];
            a    = regs[inst[25:21]];
            b    = regs[inst[20:16]];
            sext = {{16{inst[15]}}, inst[15:0]};
            addr = a + sext;
            nnpc = npc + 32'd4;
            rd   = 5'd0;
            res  = '0;
            case (inst[31:26])
                6'h00: begin
                    rd = inst[15:11];
                    case (inst[5:0])
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h26:   res = a ^ b;
                        6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        6'h2b:   res = (a < b) ? 32'd1 : 32'd0;
                        default: rd = 5'd0;
                    endcase
                end
                OP_ADDIU: begin
                    rd  = inst[20:16];
                    res = a + sext;
                end
                OP_ORI: begin
                    rd  = inst[20:16];
                    res = a | {16'h0000, inst[15:0]};
                end
                OP_LUI: begin
                    rd  = inst[20:16];
                    res = {inst[15:0], 16'h0000};
                end
                OP_LW: begin
                    rd  = inst[20:16];
                    res = mem[addr[7:2]];
                end
                OP_SW: begin
                    mem[addr[7:2]] = b;
                    st.addr = addr;
                    st.data = b;
                    exp_st.push_back(st);
                end
                OP_BEQ: begin
                    if (a == b) begin
                        nnpc = pc + 32'd4 + {sext[29:0], 2'b00};
                    end
                end
                OP_BNE: begin
                    if (a != b) begin
                        nnpc = pc + 32'd4 + {sext[29:0], 2'b00};
                    end
                end
                default: ;
            endcase
            if (rd != 5'd0) begin
                regs[rd] = res;
                wb.pc    = pc;
                wb.rd    = rd;
                wb.val   = res;
                exp_wb.push_back(wb);
            end
            pc    = npc;
            npc   = nnpc;
            steps = steps + 1;
        end
    endtask

    // Outputs are sampled mid-cycle.
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (wb_wreg != 4'h0) begin
                assert (exp_wb.size() != 0)
                    else stop_on_error($sformatf("unexpected writeback from pc %h to r%0d",
                                                 wb_pc, wb_wraddr));
                got_wb.pc  = wb_pc;
                got_wb.rd  = wb_wraddr;
                got_wb.val = wb_wrdata;
                want_wb    = exp_wb.pop_front();
                assert (got_wb == want_wb)
                    else stop_on_error($sformatf(
                        "ERR %0t: writeback pc=%h r%0d=%h, expected pc=%h r%0d=%h", $time,
                        got_wb.pc, got_wb.rd, got_wb.val, want_wb.pc, want_wb.rd, want_wb.val));
            end
            if (dbus_en) begin
                assert ((dbus_wen == 4'h0) || (dbus_wen == 4'hf))
                    else stop_on_error($sformatf("ERR %0t: partial byte enables %b",
                                                 $time, dbus_wen));
            end
            if (dbus_en && (dbus_wen != 4'h0)) begin
                assert (exp_st.size() != 0)
                    else stop_on_error($sformatf("unexpected store to address %h", dbus_addr));
                got_st.addr = dbus_addr;
                got_st.data = dbus_wdata;
                want_st     = exp_st.pop_front();
                assert (got_st == want_st)
                    else stop_on_error($sformatf(
                        "ERR %0t: store [%h]=%h, expected [%h]=%h", $time,
                        got_st.addr, got_st.data, want_st.addr, want_st.data));
            end
        end
    end

    initial begin
        int cycles;
        bit prev_branch;
        clk     = 1'b0;
        rst_n_i = 1'b0;
        void'($urandom(23));
        for (int i = 0; i < 64; i++) begin
            dmem[i] = $urandom();
        end
        for (int i = 0; i < 256; i++) begin
            imem[i] = '0;
        end
        // No branch sits in a delay slot, and none precedes the final loop.
        prev_branch = 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            imem[i]     = random_inst(i, prev_branch || (i == PROG_LEN - 1));
            prev_branch = (imem[i][31:26] == OP_BEQ) || (imem[i][31:26] == OP_BNE);
        end
        imem[PROG_LEN]     = {OP_BEQ, 5'd0, 5'd0, 16'hffff};
        imem[PROG_LEN + 1] = '0;
        run_model();

        repeat (3) @(posedge clk);
        rst_n_i <= 1'b1;
        @(negedge clk);
        assert (ibus_en && (ibus_addr == `MIPS_RESET_PC) && !dbus_en && (dbus_wen == 4'h0) &&
                (wb_wreg == 4'h0))
            else stop_on_error($sformatf("ERR %0t: wrong state after reset, fetch at %h",
                                         $time, ibus_addr));

        // The final loop branch reaching writeback means all older work has retired.
        cycles = 0;
        while ((wb_pc != END_PC) && (cycles < TIMEOUT_CYCLES)) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        assert (wb_pc == END_PC)
            else stop_on_error("timeout: the final loop was not reached within 2000 cycles");
        assert (exp_wb.size() == 0)
            else stop_on_error($sformatf("ERR %0t: %0d expected writebacks never appeared",
                                         $time, exp_wb.size()));
        assert (exp_st.size() == 0)
            else stop_on_error($sformatf("ERR %0t: %0d expected stores never appeared",
                                         $time, exp_st.size()));
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
